// File: axi_rd_pkg.sv
// AXI read-data beat only; address channel, rlast use and ID checking live outside this package

package axi_rd_pkg;

    // --------------------
    // Beat geometry
    // --------------------

    // One read beat carries a full 128-bit data word
    localparam int BEAT_W = 128;

    // --------------------
    // Response codes
    // --------------------

    // Standard AXI RRESP encoding, only OKAY counts as a clean beat
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } rd_resp_e;

    // --------------------
    // Read-data beat
    // --------------------

    // rid is kept out of the struct since its width is a module parameter
    typedef struct packed {
        logic [BEAT_W-1:0] data;
        logic              last;
        rd_resp_e          resp;
    } rd_beat_t;

endpackage

// File: quant_pkg.sv
// Quantizer header layout; beat k of the header fills bits [k*128 +: 128] of enc_params_t

package quant_pkg;

    // --------------------
    // Row geometry
    // --------------------

    // One row beat, matches the read beat width
    localparam int ROW_W = 128;

    // Sixteen 8-bit luma pixels, pixel 0 in the low byte
    typedef logic [ROW_W-1:0] y_row_t;

    // Chroma row, u in the low half and v in the high half
    typedef struct packed {
        logic [ROW_W/2-1:0] v;
        logic [ROW_W/2-1:0] u;
    } uv_row_t;

    // --------------------
    // Quantizer matrix set
    // --------------------

    // Fields listed MSB first, so q sits at bit 0 of the set
    typedef struct packed {
        logic [63:0]  sharpen;
        logic [127:0] zthresh;
        logic [127:0] bias;
        logic [63:0]  iq;
        logic [63:0]  q;
    } quant_matrix_t;

    // --------------------
    // Rate-distortion words
    // --------------------

    // Six 32-bit words, min_disto lowest
    typedef struct packed {
        logic [31:0] tlambda;
        logic [31:0] lambda_mode;
        logic [31:0] lambda_uv;
        logic [31:0] lambda_i4;
        logic [31:0] lambda_i16;
        logic [31:0] min_disto;
    } lambda_t;

    // --------------------
    // Full header
    // --------------------

    // Y1 set at bit 0, then Y2, UV and the lambda words on top
    typedef struct packed {
        lambda_t       lambda;
        quant_matrix_t uv;
        quant_matrix_t y2;
        quant_matrix_t y1;
    } enc_params_t;

    // 1536 header bits over 128-bit beats
    localparam int HDR_BEATS = $bits(enc_params_t) / ROW_W;

endpackage

// File: rdata_channel.sv
// Header fills 12 beats after start_pulse; a beat accepted in the start cycle is dropped; rid unchecked

`timescale 1ns/1ns

module rdata_channel #(
    parameter int ID_WIDTH = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // Read-data channel
    input  axi_rd_pkg::rd_beat_t   rd_beat,
    input  logic [ID_WIDTH-1:0]    rd_id,
    input  logic                   rd_valid,
    output logic                   rready,

    // Local control
    input  logic                   start_pulse,
    output logic                   rd_error,
    output quant_pkg::enc_params_t params,

    // FIFO write side
    input  logic [2:0]             fifo_full,
    output quant_pkg::y_row_t      y0_row,
    output quant_pkg::y_row_t      y1_row,
    output quant_pkg::uv_row_t     uv_row,
    output logic                   wr
);

    localparam int SLICE_W = axi_rd_pkg::BEAT_W;

    // Triplet positions follow straight after the header beats
    localparam logic [3:0] POS_Y0 = 4'(quant_pkg::HDR_BEATS);
    localparam logic [3:0] POS_Y1 = POS_Y0 + 4'd1;
    localparam logic [3:0] POS_UV = POS_Y0 + 4'd2;

    logic [3:0] beat_pos;
    logic       accept;
    logic       take;
    logic       in_header;

    // --------------------
    // Handshake
    // --------------------

    // Stall only at the start of a triplet; the two later beats always fit
    assign rready    = !((beat_pos == POS_Y0) && (|fifo_full));
    assign accept    = rd_valid && rready;
    assign take      = accept && !start_pulse;
    assign in_header = beat_pos < POS_Y0;

    // --------------------
    // Beat position
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_pos <= '0;
        end else if (start_pulse) begin
            beat_pos <= '0;
        end else if (accept) begin
            if (beat_pos == POS_UV) begin
                beat_pos <= POS_Y0;
            end else begin
                beat_pos <= beat_pos + 4'd1;
            end
        end
    end

    // --------------------
    // Header capture
    // --------------------

    // Each header beat lands in its own 128-bit slice, beat 0 lowest
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            params <= '0;
        end else if (take && in_header) begin
            params[beat_pos*SLICE_W +: SLICE_W] <= rd_beat.data;
        end
    end

    // --------------------
    // Triplet holding
    // --------------------

    // A new Y0 may land in the same edge the FIFO samples the previous row
    always_ff @(posedge clk) begin
        if (take) begin
            case (beat_pos)
                POS_Y0: y0_row <= rd_beat.data;
                POS_Y1: y1_row <= rd_beat.data;
                POS_UV: uv_row <= quant_pkg::uv_row_t'(rd_beat.data);
                default: ;
            endcase
        end
    end

    // One write strobe for all three FIFOs after the UV row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr <= 1'b0;
        end else begin
            wr <= take && (beat_pos == POS_UV);
        end
    end

    // --------------------
    // Error flag
    // --------------------

    // Tracks the response of the most recent accepted beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_error <= 1'b0;
        end else if (accept) begin
            rd_error <= (rd_beat.resp != axi_rd_pkg::RESP_OKAY);
        end
    end

endmodule

// File: beat_fifo.sv
// Show-ahead FIFO; FIFO_DEPTH must be a power of two and at least 2, pop on empty is ignored

`timescale 1ns/1ns

module beat_fifo #(
    parameter int  FIFO_DEPTH = 4,
    parameter type payload_t  = quant_pkg::y_row_t
) (
    input  logic     clk,
    input  logic     rst_n,

    // Write side
    input  logic     wr,
    input  payload_t din,
    output logic     full,

    // Read side
    input  logic     pop,
    output payload_t dout,
    output logic     empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    payload_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    // --------------------
    // Status
    // --------------------

    assign full    = count == (PTR_W+1)'(FIFO_DEPTH);
    assign empty   = count == '0;
    assign do_push = wr && !full;
    assign do_pop  = pop && !empty;

    // Head is read straight from the array
    assign dout = mem[rd_ptr];

    // --------------------
    // Storage
    // --------------------

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: mb_load_top.sv
// Macroblock loader read side; triplet reaches the FIFO heads two edges after the UV beat

`timescale 1ns/1ns

module mb_load_top #(
    parameter int ID_WIDTH   = 2,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // Read-data channel
    input  axi_rd_pkg::rd_beat_t   rd_beat,
    input  logic [ID_WIDTH-1:0]    rd_id,
    input  logic                   rd_valid,
    output logic                   rready,

    // Control and header
    input  logic                   start_pulse,
    output logic                   rd_error,
    output quant_pkg::enc_params_t params,

    // Consumer side
    input  logic                   y0_pop,
    input  logic                   y1_pop,
    input  logic                   uv_pop,
    output quant_pkg::y_row_t      y0_head,
    output quant_pkg::y_row_t      y1_head,
    output quant_pkg::uv_row_t     uv_head,
    output logic                   y0_empty,
    output logic                   y1_empty,
    output logic                   uv_empty
);

    // Bit 0 is Y0, bit 1 is Y1, bit 2 is UV
    logic [2:0]         fifo_full;
    logic               fifo_wr;
    quant_pkg::y_row_t  y0_row;
    quant_pkg::y_row_t  y1_row;
    quant_pkg::uv_row_t uv_row;

    // --------------------
    // Channel
    // --------------------

    rdata_channel #(
        .ID_WIDTH (ID_WIDTH)
    ) u_channel (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_beat     (rd_beat),
        .rd_id       (rd_id),
        .rd_valid    (rd_valid),
        .rready      (rready),
        .start_pulse (start_pulse),
        .rd_error    (rd_error),
        .params      (params),
        .fifo_full   (fifo_full),
        .y0_row      (y0_row),
        .y1_row      (y1_row),
        .uv_row      (uv_row),
        .wr          (fifo_wr)
    );

    // --------------------
    // Row FIFOs
    // --------------------

    beat_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (quant_pkg::y_row_t)
    ) fifo_y0 (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (fifo_wr),
        .din   (y0_row),
        .full  (fifo_full[0]),
        .pop   (y0_pop),
        .dout  (y0_head),
        .empty (y0_empty)
    );

    beat_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (quant_pkg::y_row_t)
    ) fifo_y1 (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (fifo_wr),
        .din   (y1_row),
        .full  (fifo_full[1]),
        .pop   (y1_pop),
        .dout  (y1_head),
        .empty (y1_empty)
    );

    beat_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (quant_pkg::uv_row_t)
    ) fifo_uv (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (fifo_wr),
        .din   (uv_row),
        .full  (fifo_full[2]),
        .pop   (uv_pop),
        .dout  (uv_head),
        .empty (uv_empty)
    );

endmodule

// File: tb_mb_load.sv
// Self-checking testbench for mb_load_top; stall cases assume FIFO_DEPTH below the triplet counts

`timescale 1ns/1ns

module tb_mb_load;

    localparam int ID_WIDTH   = 2;
    localparam int FIFO_DEPTH = 4;
    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 10;
    localparam int NUM_TESTS  = 6;

    // One table row per test, -1 marks an unused index
    typedef struct packed {
        logic [8*12-1:0] name;
        int              triplets;
        logic            pop_during;
        int              err_beat;
        int              restart_after;
    } test_row_t;

    logic                   clk;
    logic                   rst_n;
    axi_rd_pkg::rd_beat_t   rd_beat;
    logic [ID_WIDTH-1:0]    rd_id;
    logic                   rd_valid;
    logic                   rready;
    logic                   start_pulse;
    logic                   rd_error;
    quant_pkg::enc_params_t params;
    logic                   y0_pop;
    logic                   y1_pop;
    logic                   uv_pop;
    quant_pkg::y_row_t      y0_head;
    quant_pkg::y_row_t      y1_head;
    quant_pkg::uv_row_t     uv_head;
    logic                   y0_empty;
    logic                   y1_empty;
    logic                   uv_empty;

    test_row_t              table_rows [NUM_TESTS];
    quant_pkg::enc_params_t exp_params;
    logic [127:0]           exp_y0 [$];
    logic [127:0]           exp_y1 [$];
    logic [127:0]           exp_uv [$];
    logic [31:0]            lcg_state;
    int                     errors;
    int                     checks;
    int                     test_errors;
    int                     beat_idx;
    int                     cur_err_beat;

    mb_load_top #(
        .ID_WIDTH   (ID_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .clk (clk), .rst_n (rst_n),
        .rd_beat (rd_beat), .rd_id (rd_id), .rd_valid (rd_valid), .rready (rready),
        .start_pulse (start_pulse), .rd_error (rd_error), .params (params),
        .y0_pop (y0_pop), .y1_pop (y1_pop), .uv_pop (uv_pop),
        .y0_head (y0_head), .y1_head (y1_head), .uv_head (uv_head),
        .y0_empty (y0_empty), .y1_empty (y1_empty), .uv_empty (uv_empty)
    );

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [127:0] random_row();
        logic [127:0] row;
        for (int i = 0; i < 4; i++) begin
            row[i*32 +: 32] = lcg_next();
        end
        return row;
    endfunction

    function automatic axi_rd_pkg::rd_resp_e beat_resp();
        return (beat_idx == cur_err_beat) ? axi_rd_pkg::RESP_SLVERR : axi_rd_pkg::RESP_OKAY;
    endfunction

    task automatic check_val(input string name, input logic [511:0] exp_v,
                             input logic [511:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            test_errors++;
            $display("MISMATCH %s expected %0h actual %0h", name, exp_v, act_v);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        test_errors++;
        $display("ERROR %s", msg);
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // --------------------
    // Read channel driving
    // --------------------

    // Holds the beat until an edge sees rready high
    task automatic send_beat(input logic [127:0] data, input logic last);
        logic done;
        axi_rd_pkg::rd_resp_e resp;
        done = 1'b0;
        resp = beat_resp();
        rd_beat.data = data;
        rd_beat.resp = resp;
        rd_beat.last = last;
        rd_id = beat_idx[ID_WIDTH-1:0];
        rd_valid = 1'b1;
        while (!done) begin
            #1;
            done = rready;
            next_cycle();
        end
        rd_valid = 1'b0;
        beat_idx++;
        check_val("rd_error", 512'(resp != axi_rd_pkg::RESP_OKAY), 512'(rd_error));
    endtask

    task automatic start_stream();
        start_pulse = 1'b1;
        next_cycle();
        start_pulse = 1'b0;
    endtask

    task automatic send_header();
        logic [127:0] data;
        for (int k = 0; k < quant_pkg::HDR_BEATS; k++) begin
            data = random_row();
            exp_params[k*128 +: 128] = data;
            send_beat(data, 1'b0);
        end
        check_val("params.y1", 512'(exp_params.y1), 512'(params.y1));
        check_val("params.y2", 512'(exp_params.y2), 512'(params.y2));
        check_val("params.uv", 512'(exp_params.uv), 512'(params.uv));
        check_val("params.lambda", 512'(exp_params.lambda), 512'(params.lambda));
    endtask

    // --------------------
    // Consumer side
    // --------------------

    task automatic pop_rows();
        int waited;
        waited = 0;
        while ((y0_empty || y1_empty || uv_empty) && waited < 8) begin
            next_cycle();
            waited++;
        end
        if (y0_empty || y1_empty || uv_empty || exp_y0.size() == 0) begin
            report_failure("row triplet missing at the FIFO heads");
            exp_y0.delete();
            exp_y1.delete();
            exp_uv.delete();
            return;
        end
        check_val("y0_head", 512'(exp_y0.pop_front()), 512'(y0_head));
        check_val("y1_head", 512'(exp_y1.pop_front()), 512'(y1_head));
        check_val("uv_head", 512'(exp_uv.pop_front()), 512'(uv_head));
        y0_pop = 1'b1;
        y1_pop = 1'b1;
        uv_pop = 1'b1;
        next_cycle();
        y0_pop = 1'b0;
        y1_pop = 1'b0;
        uv_pop = 1'b0;
    endtask

    task automatic drain_rows();
        while (exp_y0.size() > 0) begin
            pop_rows();
        end
        check_val("y0_empty", 512'(1'b1), 512'(y0_empty));
        check_val("y1_empty", 512'(1'b1), 512'(y1_empty));
        check_val("uv_empty", 512'(1'b1), 512'(uv_empty));
    endtask

    // Offers a Y0 beat to full FIFOs, then frees one entry
    task automatic hold_at_full(input logic [127:0] data);
        rd_beat.data = data;
        rd_beat.resp = beat_resp();
        rd_beat.last = 1'b0;
        rd_valid = 1'b1;
        for (int i = 0; i < 4; i++) begin
            #1;
            check_val("rready", 512'(1'b0), 512'(rready));
            next_cycle();
        end
        check_val("y0_empty", 512'(1'b0), 512'(y0_empty));
        check_val("uv_empty", 512'(1'b0), 512'(uv_empty));
        pop_rows();
    endtask

    task automatic send_triplet(input test_row_t row);
        logic [127:0] y0;
        logic [127:0] y1;
        logic [127:0] uv;
        y0 = random_row();
        y1 = random_row();
        uv = random_row();
        if (!row.pop_during && exp_y0.size() == FIFO_DEPTH) begin
            hold_at_full(y0);
        end
        send_beat(y0, 1'b0);
        send_beat(y1, 1'b0);
        send_beat(uv, 1'b1);
        exp_y0.push_back(y0);
        exp_y1.push_back(y1);
        exp_uv.push_back(uv);
        // Gap lets the full level follow the write
        next_cycle();
        if (row.pop_during) begin
            pop_rows();
        end
    endtask

    task automatic run_test(input test_row_t row);
        test_errors = 0;
        beat_idx = 0;
        cur_err_beat = row.err_beat;
        start_stream();
        send_header();
        for (int t = 0; t < row.triplets; t++) begin
            send_triplet(row);
            if (t == row.restart_after) begin
                drain_rows();
                start_stream();
                send_header();
            end
        end
        drain_rows();
        $display("test %0s: %s, %0d errors", row.name, (test_errors == 0) ? "ok" : "failed",
                 test_errors);
    endtask

    // --------------------
    // Test table
    // --------------------

    task automatic load_table();
        table_rows[0] = '{name: "hdr_rows", triplets: 3, pop_during: 1'b1, err_beat: -1,
                          restart_after: -1};
        table_rows[1] = '{name: "backpressure", triplets: 6, pop_during: 1'b0, err_beat: -1,
                          restart_after: -1};
        table_rows[2] = '{name: "err_header", triplets: 2, pop_during: 1'b1, err_beat: 5,
                          restart_after: -1};
        table_rows[3] = '{name: "err_row", triplets: 4, pop_during: 1'b1, err_beat: 13,
                          restart_after: -1};
        table_rows[4] = '{name: "restart", triplets: 5, pop_during: 1'b1, err_beat: -1,
                          restart_after: 2};
        table_rows[5] = '{name: "restart_full", triplets: 7, pop_during: 1'b0, err_beat: -1,
                          restart_after: 1};
    endtask

    // --------------------
    // Clock, watchdog, main
    // --------------------

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Limit scales with the beats in the table
    initial begin
        longint total_beats;
        total_beats = 0;
        #1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total_beats += 12 + 3 * table_rows[i].triplets;
            if (table_rows[i].restart_after >= 0) begin
                total_beats += 12;
            end
        end
        #(RST_CYCLES * CLK_PERIOD + total_beats * CLK_PERIOD * 8);
        $display("TIMEOUT the tests did not finish within the watchdog limit");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        rd_beat = '0;
        rd_id = '0;
        rd_valid = 1'b0;
        start_pulse = 1'b0;
        y0_pop = 1'b0;
        y1_pop = 1'b0;
        uv_pop = 1'b0;
        lcg_state = 32'h2f6c;
        exp_params = '0;
        errors = 0;
        checks = 0;
        load_table();
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();
        check_val("rd_error", 512'(1'b0), 512'(rd_error));
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(table_rows[i]);
        end
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: build.f
axi_rd_pkg.sv
quant_pkg.sv
rdata_channel.sv
beat_fifo.sv
mb_load_top.sv
tb_mb_load.sv

// File: Makefile
# Verilator build and run of the macroblock loader testbench

VERILATOR ?= verilator
TOP       ?= tb_mb_load
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: simulate clean

# Build, run, then search the log for the failure line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "simulator exited with an error" >> $(LOG)
	@cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if grep -qF 'simulator exited with an error' $(LOG); then \
		echo "Simulation did not complete"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
